/* hw/bpb_params.svh */
`ifndef BPB_PARAMS_SVH
`define BPB_PARAMS_SVH

// Index bits of the direct-mapped table, 2**BPB_ENTRY_WIDTH lines
`define BPB_ENTRY_WIDTH 4

// Tag covers address bits 31 down to 2 + BPB_ENTRY_WIDTH
`define BPB_TAG_WIDTH (30 - `BPB_ENTRY_WIDTH)

// Update queue entries, equal to the credits the commit stage starts with
`define UPDQ_DEPTH 4

`endif

/* hw/bpb_pkg.sv */
package bpb_pkg;

    // ========================================
    // Basic words
    // ========================================

    typedef logic [31:0] word_t;

    // Prediction returned per fetch slot
    typedef struct packed
    {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

    // Resolved branch coming back from commit
    typedef struct packed
    {
        word_t pc;
        word_t destpc;
        logic  taken;
    } bpb_update_t;

    // ========================================
    // Two-bit saturating counter
    // ========================================

    // Upper bit is the taken prediction
    typedef enum logic [1:0]
    {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } ctr_e;

endpackage

/* hw/bpb_line.sv */
`timescale 1ns/1ps

`include "bpb_params.svh"

module bpb_line
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  bpb_pkg::word_t       [1:0] pc_predict,
    output logic                 [1:0] hit_predict,
    output bpb_pkg::bpb_result_t [1:0] destpc_predict,
    input  bpb_pkg::word_t             pc_commit,
    input  logic                       wen,
    input  bpb_pkg::bpb_result_t       destpc_commit
);
    import bpb_pkg::*;

    logic                        valid;
    logic [`BPB_TAG_WIDTH - 1:0] tag;
    logic [`BPB_TAG_WIDTH - 1:0] tag_commit;
    word_t                       destpc;
    ctr_e                        state;
    logic                        write;
    logic                        reload;

    // Weak taken falls straight back to strong not taken on a miss
    function automatic ctr_e ctr_step(input ctr_e cur, input logic taken);
        ctr_e nxt;
        case (cur)
            CTR_STRONG_NT: nxt = taken ? CTR_WEAK_NT  : CTR_STRONG_NT;
            CTR_WEAK_NT:   nxt = taken ? CTR_STRONG_T : CTR_STRONG_NT;
            CTR_WEAK_T:    nxt = taken ? CTR_STRONG_T : CTR_STRONG_NT;
            default:       nxt = taken ? CTR_STRONG_T : CTR_WEAK_T;
        endcase
        return nxt;
    endfunction

    assign tag_commit = pc_commit[31 -: `BPB_TAG_WIDTH];
    assign write      = wen && !stall;
    assign reload     = !valid || (tag != tag_commit);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            valid <= 1'b0;
        else if (write)
            valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (write)
        begin
            if (reload)
            begin
                tag    <= tag_commit;
                destpc <= destpc_commit.destpc;
                state  <= CTR_STRONG_NT;
            end
            else
                state <= ctr_step(state, destpc_commit.taken);
        end
    end

    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            hit_predict[s]           = valid && (tag == pc_predict[s][31 -: `BPB_TAG_WIDTH]);
            destpc_predict[s].taken  = hit_predict[s] && state[1];
            destpc_predict[s].destpc = destpc;
        end
    end

endmodule

/* hw/bpb_table.sv */
`timescale 1ns/1ps

`include "bpb_params.svh"

module bpb_table
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  bpb_pkg::word_t       [1:0] pc_predict,
    output logic                 [1:0] hit_predict,
    output bpb_pkg::bpb_result_t [1:0] destpc_predict,
    input  logic                       wen,
    input  bpb_pkg::bpb_update_t       upd
);
    import bpb_pkg::*;

    localparam int NUM_LINES = 1 << `BPB_ENTRY_WIDTH;

    logic        [`BPB_ENTRY_WIDTH - 1:0] upd_idx;
    logic        [`BPB_ENTRY_WIDTH - 1:0] pred_idx [2];
    logic        [NUM_LINES - 1:0]        line_wen;
    bpb_result_t                          commit_res;
    logic        [1:0]                    line_hit [NUM_LINES];
    bpb_result_t [1:0]                    line_res [NUM_LINES];

    // ========================================
    // Update port decode
    // ========================================

    assign upd_idx           = upd.pc[2 +: `BPB_ENTRY_WIDTH];
    assign commit_res.taken  = upd.taken;
    assign commit_res.destpc = upd.destpc;

    always_comb
    begin
        line_wen = '0;
        line_wen[upd_idx] = wen;
    end

    // ========================================
    // Lines
    // ========================================

    for (genvar i = 0; i < NUM_LINES; i++)
    begin : g_line
        bpb_line u_line
        (
            .clk            (clk),
            .reset          (reset),
            .stall          (stall),
            .pc_predict     (pc_predict),
            .hit_predict    (line_hit[i]),
            .destpc_predict (line_res[i]),
            .pc_commit      (upd.pc),
            .wen            (line_wen[i]),
            .destpc_commit  (commit_res)
        );
    end

    // ========================================
    // Predict port select
    // ========================================

    // Each slot looks only at the line its own index bits name
    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            pred_idx[s]       = pc_predict[s][2 +: `BPB_ENTRY_WIDTH];
            hit_predict[s]    = line_hit[pred_idx[s]][s];
            destpc_predict[s] = line_res[pred_idx[s]][s];
        end
    end

endmodule

/* hw/bpb_update_queue.sv */
`timescale 1ns/1ps

`include "bpb_params.svh"

module bpb_update_queue
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 upd_valid,
    input  bpb_pkg::bpb_update_t upd_in,
    output logic                 wen,
    output bpb_pkg::bpb_update_t upd_out,
    output logic                 credit_return
);
    import bpb_pkg::*;

    localparam int PTR_W = (`UPDQ_DEPTH > 1) ? $clog2(`UPDQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(`UPDQ_DEPTH + 1);

    bpb_update_t        mem [`UPDQ_DEPTH];
    logic [PTR_W - 1:0] wr_ptr;
    logic [PTR_W - 1:0] rd_ptr;
    logic [CNT_W - 1:0] count;
    logic               out_valid;
    logic               pop;
    logic               out_free;
    logic               fifo_rd;
    logic               bypass;
    logic               push;

    // The output stage is the head seen by the table
    assign pop      = out_valid && !stall;
    assign out_free = !out_valid || pop;
    assign fifo_rd  = out_free && (count != '0);
    assign bypass   = out_free && (count == '0) && upd_valid;
    assign push     = upd_valid && !bypass;

    assign wen           = pop;
    assign credit_return = pop;

    function automatic logic [PTR_W - 1:0] ptr_inc(input logic [PTR_W - 1:0] p);
        return (p == PTR_W'(`UPDQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (fifo_rd)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(fifo_rd);
            if (out_free)
                out_valid <= fifo_rd || bypass;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= upd_in;
        if (fifo_rd)
            upd_out <= mem[rd_ptr];
        else if (bypass)
            upd_out <= upd_in;
    end

endmodule

/* hw/next_pc_unit.sv */
`timescale 1ns/1ps

module next_pc_unit
(
    input  logic                 [1:0] hit_predict,
    input  bpb_pkg::bpb_result_t [1:0] destpc_predict,
    input  bpb_pkg::word_t       [1:0] pc_predict,
    output bpb_pkg::word_t             next_pc
);

    // Slot 0 is older in program order so its taken branch wins
    always_comb
    begin
        if (hit_predict[0] && destpc_predict[0].taken)
            next_pc = destpc_predict[0].destpc;
        else if (hit_predict[1] && destpc_predict[1].taken)
            next_pc = destpc_predict[1].destpc;
        else
            next_pc = pc_predict[0] + 32'd8;
    end

endmodule

/* hw/bpb_top.sv */
`timescale 1ns/1ps

module bpb_top
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  bpb_pkg::word_t       [1:0] pc_predict,
    input  logic                       upd_valid,
    input  bpb_pkg::bpb_update_t       upd,
    output logic                       credit_return,
    output logic                 [1:0] hit_predict,
    output bpb_pkg::bpb_result_t [1:0] destpc_predict,
    output bpb_pkg::word_t             next_pc
);
    import bpb_pkg::*;

    logic        tbl_wen;
    bpb_update_t tbl_upd;

    // ========================================
    // Update path
    // ========================================

    bpb_update_queue u_queue
    (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .upd_valid     (upd_valid),
        .upd_in        (upd),
        .wen           (tbl_wen),
        .upd_out       (tbl_upd),
        .credit_return (credit_return)
    );

    bpb_table u_table
    (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .pc_predict     (pc_predict),
        .hit_predict    (hit_predict),
        .destpc_predict (destpc_predict),
        .wen            (tbl_wen),
        .upd            (tbl_upd)
    );

    // ========================================
    // Predict path
    // ========================================

    next_pc_unit u_next_pc
    (
        .hit_predict    (hit_predict),
        .destpc_predict (destpc_predict),
        .pc_predict     (pc_predict),
        .next_pc        (next_pc)
    );

endmodule

/* tb/bpb_tb.sv */
`timescale 1ns/1ps

`include "bpb_params.svh"

module bpb_tb;
    import bpb_pkg::*;

    localparam int IDX_W      = `BPB_ENTRY_WIDTH;
    localparam int TAG_W      = `BPB_TAG_WIDTH;
    localparam int DEPTH      = `UPDQ_DEPTH;
    localparam int NUM_LINES  = 1 << IDX_W;
    localparam int WAIT_LIMIT = 50;

    logic                    clk;
    logic                    reset;
    logic                    stall;
    word_t             [1:0] pc_predict;
    logic                    upd_valid;
    bpb_update_t             upd;
    logic                    credit_return;
    logic              [1:0] hit_predict;
    bpb_result_t       [1:0] destpc_predict;
    word_t                   next_pc;

    // Values the next step drives on the falling edge
    logic                    nxt_stall;
    word_t             [1:0] nxt_pc;
    logic                    nxt_send;
    bpb_update_t             nxt_upd;

    // Reference model of the table
    logic                    m_valid [NUM_LINES];
    logic [TAG_W - 1:0]      m_tag   [NUM_LINES];
    word_t                   m_dest  [NUM_LINES];
    ctr_e                    m_ctr   [NUM_LINES];

    bpb_update_t             sent [$];
    logic [TAG_W - 1:0]      tag_pool [3];
    int                      credits;
    int                      errors;
    int                      checks;
    int                      tests;
    int                      failed_tests;
    int                      err_mark;

    bpb_top dut
    (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .pc_predict     (pc_predict),
        .upd_valid      (upd_valid),
        .upd            (upd),
        .credit_return  (credit_return),
        .hit_predict    (hit_predict),
        .destpc_predict (destpc_predict),
        .next_pc        (next_pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // Compare tasks and run control
    // ========================================

    task automatic check_hit(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_result(input string name, input bpb_result_t exp,
                                input bpb_result_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s expected taken=%b destpc=%h actual taken=%b destpc=%h",
                     $time, name, exp.taken, exp.destpc, act.taken, act.destpc);
        end
    endtask

    task automatic check_next_pc(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic end_run();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("Timeout at %0t: %s", $time, what);
        end_run();
    endtask

    task automatic start_test();
        err_mark = errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != err_mark)
        begin
            failed_tests++;
            $display("test %0d %s: fail, %0d errors", tests, name, errors - err_mark);
        end
        else
            $display("test %0d %s: pass", tests, name);
    endtask

    // ========================================
    // Reference model
    // ========================================

    function automatic ctr_e next_ctr(input ctr_e cur, input logic taken);
        case (cur)
            CTR_STRONG_NT: return taken ? CTR_WEAK_NT : CTR_STRONG_NT;
            CTR_WEAK_NT:   return taken ? CTR_STRONG_T : CTR_STRONG_NT;
            CTR_WEAK_T:    return taken ? CTR_STRONG_T : CTR_STRONG_NT;
            default:       return taken ? CTR_STRONG_T : CTR_WEAK_T;
        endcase
    endfunction

    task automatic model_apply(input bpb_update_t u);
        logic [IDX_W - 1:0] idx;
        logic [TAG_W - 1:0] tag;
        idx = u.pc[2 +: IDX_W];
        tag = u.pc[31 -: TAG_W];
        if (!m_valid[idx] || m_tag[idx] != tag)
        begin
            m_valid[idx] = 1'b1;
            m_tag[idx]   = tag;
            m_dest[idx]  = u.destpc;
            m_ctr[idx]   = CTR_STRONG_NT;
        end
        else
            m_ctr[idx] = next_ctr(m_ctr[idx], u.taken);
    endtask

    task automatic check_predictions();
        logic        [1:0] exp_hit;
        bpb_result_t [1:0] exp_res;
        word_t             exp_next;
        logic [IDX_W - 1:0] idx;
        for (int s = 0; s < 2; s++)
        begin
            idx                = pc_predict[s][2 +: IDX_W];
            exp_hit[s]         = m_valid[idx] && (m_tag[idx] == pc_predict[s][31 -: TAG_W]);
            exp_res[s].taken   = exp_hit[s] && m_ctr[idx][1];
            exp_res[s].destpc  = m_dest[idx];
        end
        check_hit("hit_predict", exp_hit, hit_predict);
        for (int s = 0; s < 2; s++)
        begin
            if (exp_hit[s])
                check_result($sformatf("destpc_predict[%0d]", s), exp_res[s], destpc_predict[s]);
        end
        if (exp_res[0].taken)
            exp_next = exp_res[0].destpc;
        else if (exp_res[1].taken)
            exp_next = exp_res[1].destpc;
        else
            exp_next = pc_predict[0] + 32'd8;
        check_next_pc("next_pc", exp_next, next_pc);
    endtask

    // ========================================
    // Stimulus
    // ========================================

    function automatic word_t make_pc(input int tsel, input logic [IDX_W - 1:0] idx);
        return {tag_pool[tsel], idx, 2'b00};
    endfunction

    function automatic word_t rand_target();
        word_t t;
        t      = $urandom;
        t[1:0] = 2'b00;
        return t;
    endfunction

    // One clock cycle; outputs are checked a little after the falling edge
    task automatic step();
        @(negedge clk);
        stall      = nxt_stall;
        pc_predict = nxt_pc;
        upd_valid  = nxt_send;
        upd        = nxt_upd;
        if (nxt_send)
        begin
            sent.push_back(nxt_upd);
            credits--;
        end
        nxt_send = 1'b0;
        #1;
        check_predictions();
        if (credit_return)
        begin
            if (stall)
            begin
                errors++;
                $display("Credit returned at %0t while stall was high", $time);
            end
            if (sent.size() == 0)
            begin
                errors++;
                $display("Credit returned at %0t with no update outstanding", $time);
            end
            else
                model_apply(sent.pop_front());
            credits++;
        end
    endtask

    task automatic send_update(input word_t pc, input word_t dest, input logic taken);
        int n;
        n = 0;
        while (credits == 0)
        begin
            step();
            n++;
            if (n > WAIT_LIMIT)
                timeout_fail("no credit came back while waiting to send an update");
        end
        nxt_upd.pc     = pc;
        nxt_upd.destpc = dest;
        nxt_upd.taken  = taken;
        nxt_send       = 1'b1;
        step();
    endtask

    // Waits for every credit, then one more cycle so the last write is visible
    task automatic wait_drain();
        int n;
        n         = 0;
        nxt_stall = 1'b0;
        while (credits != DEPTH)
        begin
            step();
            n++;
            if (n > WAIT_LIMIT)
                timeout_fail("updates did not drain from the queue");
        end
        step();
    endtask

    initial
    begin
        word_t              pc_a;
        word_t              pc_b;
        word_t              pc_c;
        word_t              dest;
        logic [IDX_W - 1:0] idx;
        bpb_result_t        exp_res;

        void'($urandom(76451));
        reset      = 1'b1;
        stall      = 1'b0;
        pc_predict = '0;
        upd_valid  = 1'b0;
        upd        = '0;
        nxt_stall  = 1'b0;
        nxt_pc     = '0;
        nxt_send   = 1'b0;
        nxt_upd    = '0;
        credits    = DEPTH;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        failed_tests = 0;
        for (int i = 0; i < NUM_LINES; i++)
        begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_dest[i]  = '0;
            m_ctr[i]   = CTR_STRONG_NT;
        end
        // Low tag bits keep the pool entries distinct
        for (int k = 0; k < 3; k++)
        begin
            tag_pool[k]      = TAG_W'($urandom);
            tag_pool[k][1:0] = 2'(k);
        end

        repeat (3) @(negedge clk);
        reset = 1'b0;

        start_test();
        for (int i = 0; i < 20; i++)
        begin
            nxt_pc[0] = make_pc(int'($urandom % 3), IDX_W'($urandom));
            nxt_pc[1] = make_pc(int'($urandom % 3), IDX_W'($urandom));
            step();
            check_hit("hit_predict", 2'b00, hit_predict);
            check_next_pc("next_pc", pc_predict[0] + 32'd8, next_pc);
        end
        finish_test("after reset");

        start_test();
        idx    = IDX_W'($urandom);
        pc_a   = make_pc(0, idx);
        pc_b   = make_pc(1, idx);
        dest   = rand_target();
        nxt_pc = {pc_b, pc_a};
        send_update(pc_a, dest, 1'($urandom));
        wait_drain();
        exp_res.taken  = 1'b0;
        exp_res.destpc = dest;
        check_hit("hit_predict", 2'b01, hit_predict);
        check_result("destpc_predict[0]", exp_res, destpc_predict[0]);
        finish_test("first update");

        // Fixed start walks 00 01 11 11 10 00 01, then random outcomes
        start_test();
        for (int i = 0; i < 16; i++)
        begin
            logic taken;
            if (i < 6)
                taken = (i < 3) || (i == 5);
            else
                taken = 1'($urandom);
            send_update(pc_a, rand_target(), taken);
            wait_drain();
        end
        finish_test("counter walk");

        start_test();
        send_update(pc_a, rand_target(), 1'b1);
        send_update(pc_a, rand_target(), 1'b1);
        wait_drain();
        pc_c   = make_pc(2, idx);
        dest   = rand_target();
        nxt_pc = {pc_a, pc_c};
        send_update(pc_c, dest, 1'b1);
        wait_drain();
        exp_res.taken  = 1'b0;
        exp_res.destpc = dest;
        check_hit("hit_predict", 2'b01, hit_predict);
        check_result("destpc_predict[0]", exp_res, destpc_predict[0]);
        finish_test("conflict reload");

        start_test();
        nxt_stall = 1'b1;
        for (int i = 0; i < DEPTH; i++)
            send_update(make_pc(int'($urandom % 3), idx), rand_target(), 1'($urandom));
        for (int i = 0; i < 20; i++)
            step();
        if (credits != 0)
        begin
            errors++;
            $display("A credit came back while stall was held high");
        end
        wait_drain();
        finish_test("back-pressure");

        start_test();
        for (int i = 0; i < 400; i++)
        begin
            nxt_pc[0] = make_pc(int'($urandom % 3), IDX_W'($urandom));
            nxt_pc[1] = make_pc(int'($urandom % 3), IDX_W'($urandom));
            nxt_stall = ($urandom % 5) == 0;
            if (credits > 0 && ($urandom % 2) == 0)
            begin
                nxt_upd.pc     = make_pc(int'($urandom % 3), IDX_W'($urandom));
                nxt_upd.destpc = rand_target();
                nxt_upd.taken  = 1'($urandom);
                nxt_send       = 1'b1;
            end
            step();
        end
        wait_drain();
        finish_test("dual-slot random run");

        end_run();
    end

endmodule

/* sources.f */
+incdir+hw
hw/bpb_pkg.sv
hw/bpb_line.sv
hw/bpb_table.sv
hw/bpb_update_queue.sv
hw/next_pc_unit.sv
hw/bpb_top.sv
tb/bpb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the branch prediction buffer testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sources.f --top-module bpb_tb -Mdir obj_dir -o bpb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/bpb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
    echo "simulation log holds no result"
    exit 1
fi
exit 0
